// File: files.f
+incdir+source
source/hyperbus_pkg.sv
source/hyperbus_if.sv
source/hyperbus_axi_ctrl.sv
source/hyperbus_ca_encoder.sv
source/hyperbus_tx_buffer.sv
source/hyperbus_rx_buffer.sv
source/hyperbus_bridge.sv
bench/hyperbus_phy_model.sv
bench/tb_hyperbus_bridge.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_hyperbus_bridge
FILELIST  := files.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_hyperbus_bridge.sv
/*
  Directed tests of the AXI to HyperBus bridge against the PHY model.
  Only one test at a time drives the bus, except the priority test.
*/
`timescale 1ns/1ps
`include "hyperbus_defs.svh"

module tb_hyperbus_bridge;

    localparam int TIMEOUT = 2000;  // Clocks per wait

    logic clk_i, rst_ni;
    logic [31:0] ar_addr_i, aw_addr_i;
    logic [7:0] ar_len_i, aw_len_i;
    logic [1:0] ar_burst_i, aw_burst_i;
    logic ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
    logic [`HB_DATA_W-1:0] w_data_i, r_data_o;
    logic [`HB_STRB_W-1:0] w_strb_i;
    logic w_last_i, w_valid_i, w_ready_o;
    logic r_last_o, r_valid_o, r_ready_i, b_valid_o, b_ready_i;
    logic [1:0] r_resp_o, b_resp_o;
    logic [`HB_DATA_W-1:0] phy_ca_data_o, phy_tx_data_o, phy_rx_data_i;
    logic [`HB_NR_CS-1:0] phy_ca_cs_no;
    logic [`HB_BURST_W-1:0] phy_ca_len_o;
    logic [`HB_STRB_W-1:0] phy_tx_mask_o;
    logic phy_ca_valid_o, phy_ca_credit_i, phy_tx_last_o, phy_tx_valid_o, phy_tx_credit_i;
    logic phy_rx_last_i, phy_rx_error_i, phy_rx_valid_i, phy_rx_credit_o;
    logic phy_wr_done_i, phy_wr_error_i;

    logic [28:0] err_limit;
    logic [7:0]  tx_pause;
    logic [31:0] lcg_state;
    int          checks, errors, timed_out;
    logic [15:0] wr_q[$];
    logic [15:0] rd_data_q[$];
    logic [1:0]  rd_resp_q[$];
    logic        rd_last_q[$];
    logic [1:0]  b_resp;

    hyperbus_bridge u_dut (.*);

    hyperbus_phy_model u_phy (
        .clk_i, .rst_ni, .err_limit_i(err_limit), .tx_pause_i(tx_pause),
        .ca_data_i(phy_ca_data_o), .ca_cs_n_i(phy_ca_cs_no), .ca_len_i(phy_ca_len_o),
        .ca_valid_i(phy_ca_valid_o), .ca_credit_o(phy_ca_credit_i),
        .tx_data_i(phy_tx_data_o), .tx_mask_i(phy_tx_mask_o), .tx_last_i(phy_tx_last_o),
        .tx_valid_i(phy_tx_valid_o), .tx_credit_o(phy_tx_credit_i),
        .rx_data_o(phy_rx_data_i), .rx_last_o(phy_rx_last_i), .rx_error_o(phy_rx_error_i),
        .rx_valid_o(phy_rx_valid_i), .rx_credit_i(phy_rx_credit_o),
        .wr_done_o(phy_wr_done_i), .wr_error_o(phy_wr_error_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0 && timed_out == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: the bridge never gave %s", what);
        timed_out = 1;
        finish_run();
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s finished with %0d errors", name, errors - errs_before);
    endtask

    // Write burst of wr_q contents, response into b_resp
    task automatic axi_write(input logic [31:0] addr, input logic [1:0] strb);
        int n;
        @(posedge clk_i);
        aw_addr_i  <= addr;
        aw_len_i   <= 8'(wr_q.size() - 1);
        aw_burst_i <= 2'b01;
        aw_valid_i <= 1'b1;
        n = 0;
        do begin
            @(negedge clk_i);
            if (++n > TIMEOUT) stop_on_timeout("aw_ready_o");
        end while (!aw_ready_o);
        @(posedge clk_i);
        aw_valid_i <= 1'b0;
        for (int i = 0; i < wr_q.size(); i++) begin
            w_data_i  <= wr_q[i];
            w_strb_i  <= strb;
            w_last_i  <= (i == wr_q.size() - 1);
            w_valid_i <= 1'b1;
            n = 0;
            do begin
                @(negedge clk_i);
                if (++n > TIMEOUT) stop_on_timeout("w_ready_o");
            end while (!w_ready_o);
            @(posedge clk_i);
        end
        w_valid_i <= 1'b0;
        n = 0;
        do begin
            @(negedge clk_i);
            if (++n > TIMEOUT) stop_on_timeout("b_valid_o");
        end while (!b_valid_o);
        b_resp = b_resp_o;
        @(posedge clk_i);
        b_ready_i <= 1'b1;
        @(posedge clk_i);
        b_ready_i <= 1'b0;
    endtask

    // Read burst, r_ready_i low for hold clocks after the address
    task automatic axi_read(input logic [31:0] addr, input int beats, input int hold);
        int n;
        rd_data_q.delete();
        rd_resp_q.delete();
        rd_last_q.delete();
        @(posedge clk_i);
        ar_addr_i  <= addr;
        ar_len_i   <= 8'(beats - 1);
        ar_burst_i <= 2'b01;
        ar_valid_i <= 1'b1;
        n = 0;
        do begin
            @(negedge clk_i);
            if (++n > TIMEOUT) stop_on_timeout("ar_ready_o");
        end while (!ar_ready_o);
        @(posedge clk_i);
        ar_valid_i <= 1'b0;
        repeat (hold) @(posedge clk_i);
        r_ready_i <= 1'b1;
        n = 0;
        while (rd_data_q.size() < beats) begin
            @(negedge clk_i);
            if (++n > TIMEOUT) stop_on_timeout("r_valid_o");
            if (r_valid_o && r_ready_i) begin
                rd_data_q.push_back(r_data_o);
                rd_resp_q.push_back(r_resp_o);
                rd_last_q.push_back(r_last_o);
                n = 0;
            end
        end
        @(posedge clk_i);
        r_ready_i <= 1'b0;
    endtask

    task automatic test_reset();
        int e = errors;
        int n = 0;
        @(negedge clk_i);
        check("idle outputs", {ar_ready_o, aw_ready_o, w_ready_o, r_valid_o, b_valid_o,
              phy_ca_valid_o, phy_tx_valid_o}, '0);
        while (u_phy.rx_credit_cnt < `HB_RX_DEPTH) begin
            @(negedge clk_i);
            if (++n > TIMEOUT) stop_on_timeout("the initial read credits");
        end
        repeat (8) @(negedge clk_i);
        check("initial rx credits", u_phy.rx_credit_cnt, `HB_RX_DEPTH);
        report_test("reset", e);
    endtask

    task automatic test_single();
        int e = errors;
        logic [31:0] addr = 32'h8000_0046;  // Register space bit set, CS 0
        logic [28:0] word;
        logic [15:0] d;
        word = addr[29:1];
        d = 16'(lcg_next());
        wr_q = '{d};
        axi_write(addr, 2'b01);
        check("CA read flag", u_phy.last_ca.f.read, 0);
        check("CA space", u_phy.last_ca.f.space, 1);
        check("CA linear", u_phy.last_ca.f.linear, 1);
        check("CA upper address", u_phy.last_ca.f.addr_hi, 32'(word[28:3]));
        check("CA reserved", u_phy.last_ca.f.rsvd, 0);
        check("CA lower address", u_phy.last_ca.f.addr_lo, word[2:0]);
        check("CA chip select", u_phy.last_cs, 2'b10);
        check("write resp", b_resp, 2'b00);
        axi_read(addr, 1, 0);
        check("CA read flag", u_phy.last_ca.f.read, 1);
        check("low byte write", rd_data_q[0], {word[7:0], d[7:0]});  // High byte keeps fill
        check("read resp", rd_resp_q[0], 2'b00);
        report_test("single", e);
    endtask

    task automatic test_burst(input string name, input logic [31:0] addr, input int hold);
        int e = errors;
        wr_q.delete();
        for (int i = 0; i < 8; i++) wr_q.push_back(16'(lcg_next()));
        axi_write(addr, 2'b11);
        check("write CA len", u_phy.last_len, 8);
        check("write resp", b_resp, 2'b00);
        axi_read(addr, 8, hold);
        check("read CA len", u_phy.last_len, 8);
        for (int i = 0; i < 8; i++) begin
            check("read data", rd_data_q[i], wr_q[i]);
            check("read last", rd_last_q[i], i == 7);
        end
        check("PHY beats without credit", u_phy.violations, 0);
        report_test(name, e);
    endtask

    task automatic test_priority();
        int e = errors;
        time rd_end, wr_end;
        wr_q = '{16'h1234, 16'h5678};
        fork
            begin
                axi_read(32'h0000_0100, 2, 0);
                rd_end = $time;
            end
            begin
                axi_write(32'h0000_0340, 2'b11);
                wr_end = $time;
            end
        join
        check("read finished first", rd_end < wr_end, 1);
        check("write resp", b_resp, 2'b00);
        report_test("priority", e);
    endtask

    task automatic test_errors();
        int e = errors;
        axi_read(32'h0010_0000, 4, 0);  // Word address far above the limit
        for (int i = 0; i < 4; i++) check("read error resp", rd_resp_q[i], 2'b10);
        wr_q = '{16'hbeef};
        axi_write(32'h0010_0000, 2'b11);
        check("write error resp", b_resp, 2'b10);
        report_test("errors", e);
    endtask

    initial begin
        lcg_state = 32'h620f_4572;
        checks = 0;
        errors = 0;
        timed_out = 0;
        err_limit = 29'h0000_1000;
        tx_pause = 8'd0;
        rst_ni = 1'b0;
        {ar_addr_i, ar_len_i, ar_burst_i, ar_valid_i} = '0;
        {aw_addr_i, aw_len_i, aw_burst_i, aw_valid_i} = '0;
        {w_data_i, w_strb_i, w_last_i, w_valid_i} = '0;
        r_ready_i = 1'b0;
        b_ready_i = 1'b0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        test_reset();
        test_single();
        test_burst("burst", 32'h0000_0100, 0);
        tx_pause = 8'd6;  // Slow write credits
        test_burst("backpressure", 32'h0000_0200, 30);
        tx_pause = 8'd0;
        test_priority();
        test_errors();
        finish_run();
    end

endmodule

// File: bench/hyperbus_phy_model.sv
/*
  PHY and memory model for the bridge testbench. 256-word memory, the word
  address wraps on its low 8 bits. Words above err_limit_i answer with error.
  Write beats wait in a queue until their CA word is decoded.
  Write credits come back one per beat, spaced by tx_pause_i clocks.
*/
`timescale 1ns/1ps
`include "hyperbus_defs.svh"

module hyperbus_phy_model import hyperbus_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [28:0]            err_limit_i,
    input  logic [7:0]             tx_pause_i,
    input  logic [`HB_DATA_W-1:0]  ca_data_i,
    input  logic [`HB_NR_CS-1:0]   ca_cs_n_i,
    input  logic [`HB_BURST_W-1:0] ca_len_i,
    input  logic                   ca_valid_i,
    output logic                   ca_credit_o,
    input  logic [`HB_DATA_W-1:0]  tx_data_i,
    input  logic [`HB_STRB_W-1:0]  tx_mask_i,
    input  logic                   tx_last_i,
    input  logic                   tx_valid_i,
    output logic                   tx_credit_o,
    output logic [`HB_DATA_W-1:0]  rx_data_o,
    output logic                   rx_last_o,
    output logic                   rx_error_o,
    output logic                   rx_valid_o,
    input  logic                   rx_credit_i,
    output logic                   wr_done_o,
    output logic                   wr_error_o
);

    logic [`HB_DATA_W-1:0]  mem [256];
    logic [1:0]             beat_q;
    logic [31:0]            ca_buf_q;  // First two CA beats
    hb_ca_t                 ca_w;
    hb_ca_t                 last_ca;
    logic [`HB_BURST_W-1:0] last_len;
    logic [`HB_NR_CS-1:0]   last_cs;
    logic [28:0]            word_w, wr_ptr, rd_ptr;
    logic [`HB_BURST_W-1:0] rd_left;
    logic                   rd_err, wr_err;
    logic                   wr_open;   // Write CA decoded, beats may land
    logic [18:0]            tx_q[$];   // {last, mask, data}
    logic [18:0]            tx_beat;
    logic                   tx_give, rx_send;
    int                     tx_avail, tx_owed, gap, rx_avail, rx_credit_cnt, violations;

    assign tx_give = (tx_owed > 0) && (gap >= int'(tx_pause_i));
    assign rx_send = (rd_left != '0) && (rx_avail > 0);

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < 256; i++) mem[i] <= {i[7:0], ~i[7:0]};
            beat_q <= '0;
            rd_left <= '0;
            wr_open <= 1'b0;
            tx_q.delete();
            tx_avail <= `HB_TX_CREDITS;
            tx_owed <= 0;
            gap <= 0;
            rx_avail <= 0;
            rx_credit_cnt <= 0;
            violations <= 0;
            ca_credit_o <= 1'b0;
            tx_credit_o <= 1'b0;
            rx_data_o <= '0;
            rx_last_o <= 1'b0;
            rx_error_o <= 1'b0;
            rx_valid_o <= 1'b0;
            wr_done_o <= 1'b0;
            wr_error_o <= 1'b0;
        end else begin
            ca_credit_o <= ca_valid_i;  // CA beats drain at once
            if (ca_valid_i) begin
                beat_q <= (beat_q == 2'd2) ? 2'd0 : beat_q + 2'd1;
                ca_buf_q <= {ca_buf_q[15:0], ca_data_i};
                if (beat_q == 2'd2) begin
                    ca_w.raw = {ca_buf_q, ca_data_i};
                    word_w = {ca_w.f.addr_hi[25:0], ca_w.f.addr_lo};
                    last_ca <= ca_w;
                    last_len <= ca_len_i;
                    last_cs <= ca_cs_n_i;
                    if (ca_w.f.read) begin
                        rd_ptr <= word_w;
                        rd_left <= ca_len_i;
                        rd_err <= word_w > err_limit_i;
                    end else begin
                        wr_ptr <= word_w;
                        wr_err <= word_w > err_limit_i;
                        wr_open <= 1'b1;
                    end
                end
            end

            // Write side, merged by the mask
            if (tx_valid_i && tx_avail == 0) violations <= violations + 1;
            tx_avail <= tx_avail - int'(tx_valid_i) + int'(tx_credit_o);
            tx_owed <= tx_owed + int'(tx_valid_i) - int'(tx_give);
            tx_credit_o <= tx_give;
            gap <= tx_give ? 0 : (gap < 255 ? gap + 1 : gap);
            if (tx_valid_i) tx_q.push_back({tx_last_i, tx_mask_i, tx_data_i});
            wr_done_o <= 1'b0;
            if (wr_open && tx_q.size() > 0) begin
                tx_beat = tx_q.pop_front();
                mem[wr_ptr[7:0]] <= {tx_beat[17] ? mem[wr_ptr[7:0]][15:8] : tx_beat[15:8],
                                     tx_beat[16] ? mem[wr_ptr[7:0]][7:0] : tx_beat[7:0]};
                wr_ptr <= wr_ptr + 29'd1;
                if (tx_beat[18]) begin
                    wr_done_o <= 1'b1;
                    wr_error_o <= wr_err;
                    wr_open <= 1'b0;
                end
            end

            // Read side, only against bridge credits
            rx_credit_cnt <= rx_credit_cnt + int'(rx_credit_i);
            rx_avail <= rx_avail + int'(rx_credit_i) - int'(rx_send);
            rx_valid_o <= rx_send;
            if (rx_send) begin
                rx_data_o <= mem[rd_ptr[7:0]];
                rx_last_o <= (rd_left == `HB_BURST_W'(1));
                rx_error_o <= rd_err;
                rd_ptr <= rd_ptr + 29'd1;
                rd_left <= rd_left - `HB_BURST_W'(1);
            end
        end
    end

endmodule

// File: source/hyperbus_bridge.sv
/*
  AXI to HyperBus bridge top. Plain AXI ports on one side, the three
  credit-based PHY channels and write completion on the other.
*/
`timescale 1ns/1ps
`include "hyperbus_defs.svh"

module hyperbus_bridge (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic [31:0]            ar_addr_i,
    input  logic [7:0]             ar_len_i,
    input  logic [1:0]             ar_burst_i,
    input  logic                   ar_valid_i,
    output logic                   ar_ready_o,
    input  logic [31:0]            aw_addr_i,
    input  logic [7:0]             aw_len_i,
    input  logic [1:0]             aw_burst_i,
    input  logic                   aw_valid_i,
    output logic                   aw_ready_o,
    input  logic [`HB_DATA_W-1:0]  w_data_i,
    input  logic [`HB_STRB_W-1:0]  w_strb_i,
    input  logic                   w_last_i,
    input  logic                   w_valid_i,
    output logic                   w_ready_o,
    output logic [`HB_DATA_W-1:0]  r_data_o,
    output logic                   r_last_o,
    output logic [1:0]             r_resp_o,
    output logic                   r_valid_o,
    input  logic                   r_ready_i,
    output logic [1:0]             b_resp_o,
    output logic                   b_valid_o,
    input  logic                   b_ready_i,
    output logic [`HB_DATA_W-1:0]  phy_ca_data_o,  // CA channel
    output logic [`HB_NR_CS-1:0]   phy_ca_cs_no,
    output logic [`HB_BURST_W-1:0] phy_ca_len_o,
    output logic                   phy_ca_valid_o,
    input  logic                   phy_ca_credit_i,
    output logic [`HB_DATA_W-1:0]  phy_tx_data_o,  // Write data
    output logic [`HB_STRB_W-1:0]  phy_tx_mask_o,
    output logic                   phy_tx_last_o,
    output logic                   phy_tx_valid_o,
    input  logic                   phy_tx_credit_i,
    input  logic [`HB_DATA_W-1:0]  phy_rx_data_i,  // Read data
    input  logic                   phy_rx_last_i,
    input  logic                   phy_rx_error_i,
    input  logic                   phy_rx_valid_i,
    output logic                   phy_rx_credit_o,
    input  logic                   phy_wr_done_i,
    input  logic                   phy_wr_error_i
);

    hyperbus_cmd_if    cmd ();
    hyperbus_stream_if tx ();
    hyperbus_stream_if rx ();

    hyperbus_axi_ctrl u_ctrl (.cmd(cmd), .tx(tx), .rx(rx), .*);

    hyperbus_ca_encoder u_enc (.cmd(cmd), .*);

    hyperbus_tx_buffer u_tx (.tx(tx), .*);

    hyperbus_rx_buffer u_rx (.rx(rx), .*);

endmodule

// File: source/hyperbus_rx_buffer.sv
/*
  Read data FIFO from the PHY. Grants one credit per free slot, the first
  HB_RX_DEPTH credits right after reset. The PHY must not send without credit.
*/
`timescale 1ns/1ps
`include "hyperbus_defs.svh"

module hyperbus_rx_buffer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [`HB_DATA_W-1:0] phy_rx_data_i,
    input  logic                  phy_rx_last_i,
    input  logic                  phy_rx_error_i,
    input  logic                  phy_rx_valid_i,
    output logic                  phy_rx_credit_o,
    hyperbus_stream_if.src        rx
);

    localparam int PtrW = $clog2(`HB_RX_DEPTH);
    localparam int CntW = $clog2(`HB_RX_DEPTH + 1);

    logic [`HB_DATA_W-1:0] data_mem [`HB_RX_DEPTH];
    logic                  last_mem [`HB_RX_DEPTH];
    logic                  err_mem  [`HB_RX_DEPTH];
    logic [PtrW-1:0]       wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0]       cnt_q;
    logic [CntW-1:0]       owed_q;  // Credits not yet handed out
    logic                  credit_q;
    logic                  pop, give;

    assign pop  = rx.valid & rx.ready;
    assign give = (owed_q != '0);

    always_ff @(posedge clk_i) begin
        if (phy_rx_valid_i) begin
            data_mem[wr_ptr_q] <= phy_rx_data_i;
            last_mem[wr_ptr_q] <= phy_rx_last_i;
            err_mem[wr_ptr_q]  <= phy_rx_error_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            owed_q   <= CntW'(`HB_RX_DEPTH);  // Whole FIFO free at start
            credit_q <= 1'b0;
        end else begin
            if (phy_rx_valid_i) wr_ptr_q <= wr_ptr_q + PtrW'(1);
            if (pop) rd_ptr_q <= rd_ptr_q + PtrW'(1);
            cnt_q    <= cnt_q + CntW'(phy_rx_valid_i) - CntW'(pop);
            owed_q   <= owed_q - CntW'(give) + CntW'(pop);
            credit_q <= give;  // One pulse per clock
        end
    end

    assign phy_rx_credit_o = credit_q;

    assign rx.valid = (cnt_q != '0);
    assign rx.data  = data_mem[rd_ptr_q];
    assign rx.last  = last_mem[rd_ptr_q];
    assign rx.error = err_mem[rd_ptr_q];
    assign rx.strb  = '1;  // Reads always return whole words

    // Catches a PHY that ignores the credit count
    a_rx_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        phy_rx_valid_i |-> cnt_q < CntW'(`HB_RX_DEPTH));

endmodule

// File: source/hyperbus_tx_buffer.sv
/*
  Write data FIFO toward the PHY. Mask bits are active high, a set bit
  leaves the byte untouched. Drains only while PHY credits remain.
*/
`timescale 1ns/1ps
`include "hyperbus_defs.svh"

module hyperbus_tx_buffer (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    hyperbus_stream_if.dst        tx,
    output logic [`HB_DATA_W-1:0] phy_tx_data_o,
    output logic [`HB_STRB_W-1:0] phy_tx_mask_o,
    output logic                  phy_tx_last_o,
    output logic                  phy_tx_valid_o,
    input  logic                  phy_tx_credit_i
);

    localparam int PtrW = $clog2(`HB_TX_DEPTH);
    localparam int CntW = $clog2(`HB_TX_DEPTH + 1);
    localparam int CrdW = $clog2(`HB_TX_CREDITS + 1);

    logic [`HB_DATA_W-1:0] data_mem [`HB_TX_DEPTH];
    logic [`HB_STRB_W-1:0] mask_mem [`HB_TX_DEPTH];
    logic                  last_mem [`HB_TX_DEPTH];
    logic [PtrW-1:0]       wr_ptr_q, rd_ptr_q;
    logic [CntW-1:0]       cnt_q;
    logic [CrdW-1:0]       credit_q;
    logic                  push, pop;

    assign tx.ready = (cnt_q != CntW'(`HB_TX_DEPTH));
    assign push     = tx.valid & tx.ready;
    assign pop      = phy_tx_valid_o;

    always_ff @(posedge clk_i) begin
        if (push) begin
            data_mem[wr_ptr_q] <= tx.data;
            mask_mem[wr_ptr_q] <= ~tx.strb | {`HB_STRB_W{tx.error}};  // Error masks all
            last_mem[wr_ptr_q] <= tx.last;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
            credit_q <= CrdW'(`HB_TX_CREDITS);
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + PtrW'(1);
            if (pop) rd_ptr_q <= rd_ptr_q + PtrW'(1);
            cnt_q    <= cnt_q + CntW'(push) - CntW'(pop);
            credit_q <= credit_q - CrdW'(pop) + CrdW'(phy_tx_credit_i);
        end
    end

    assign phy_tx_valid_o = (cnt_q != '0) && (credit_q != '0);
    assign phy_tx_data_o  = data_mem[rd_ptr_q];
    assign phy_tx_mask_o  = mask_mem[rd_ptr_q];
    assign phy_tx_last_o  = last_mem[rd_ptr_q];

    a_tx_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        push |-> cnt_q < CntW'(`HB_TX_DEPTH));

endmodule

// File: source/hyperbus_ca_encoder.sv
/*
  Builds the 48-bit CA word and sends it as three beats under CA credits.
  Only address bits 29..1 reach the memory, bit 31 selects register space.
*/
`timescale 1ns/1ps
`include "hyperbus_defs.svh"

module hyperbus_ca_encoder import hyperbus_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    hyperbus_cmd_if.enc            cmd,
    output logic [`HB_DATA_W-1:0]  phy_ca_data_o,
    output logic [`HB_NR_CS-1:0]   phy_ca_cs_no,
    output logic [`HB_BURST_W-1:0] phy_ca_len_o,
    output logic                   phy_ca_valid_o,
    input  logic                   phy_ca_credit_i
);

    localparam int CntW = $clog2(`HB_CA_CREDITS + 1);

    hb_ca_t                 ca_d, ca_q;
    logic                   busy_q;
    logic [1:0]             beat_q;
    logic [CntW-1:0]        credit_q;
    logic [`HB_BURST_W-1:0] len_q;
    logic [`HB_NR_CS-1:0]   cs_q;
    logic                   accept;

    assign cmd.ready = ~busy_q;
    assign accept    = cmd.valid & cmd.ready;

    always_comb begin
        ca_d           = '0;
        ca_d.f.read    = ~cmd.write;
        ca_d.f.space   = cmd.addr[31];
        ca_d.f.linear  = cmd.burst_type[0];  // INCR maps to linear
        ca_d.f.addr_hi = 29'(cmd.addr[29:4]);
        ca_d.f.addr_lo = cmd.addr[3:1];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            busy_q   <= 1'b0;
            beat_q   <= '0;
            credit_q <= CntW'(`HB_CA_CREDITS);
            cs_q     <= '1;
        end else begin
            credit_q <= credit_q - CntW'(phy_ca_valid_o) + CntW'(phy_ca_credit_i);
            if (accept) begin
                busy_q <= 1'b1;
                beat_q <= '0;
                cs_q   <= cmd.cs_n;
            end else if (phy_ca_valid_o) begin
                beat_q <= beat_q + 2'd1;
                if (beat_q == 2'd2) busy_q <= 1'b0;
            end
        end
    end

    // Shift register, top beat is always the one on the bus
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ca_q  <= ca_d;
            len_q <= `HB_BURST_W'(cmd.len) + `HB_BURST_W'(1);
        end else if (phy_ca_valid_o) begin
            ca_q.raw <= {ca_q.raw[1:0], {`HB_DATA_W{1'b0}}};
        end
    end

    assign phy_ca_valid_o = busy_q && (credit_q != '0);  // Stall holds data
    assign phy_ca_data_o  = ca_q.raw[2];
    assign phy_ca_len_o   = len_q;
    assign phy_ca_cs_no   = cs_q;

    // PHY returns no more than it was given
    a_ca_credit_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
        credit_q <= CntW'(`HB_CA_CREDITS));

endmodule

// File: source/hyperbus_axi_ctrl.sv
/*
  Bridge control FSM. One burst at a time, reads win over writes.
  Chip select comes from address bit 30. Write beats beyond len are
  flagged so the PHY sees them fully masked.
*/
`timescale 1ns/1ps
`include "hyperbus_defs.svh"

module hyperbus_axi_ctrl import hyperbus_pkg::*; (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic [31:0]           ar_addr_i,
    input  logic [7:0]            ar_len_i,
    input  logic [1:0]            ar_burst_i,
    input  logic                  ar_valid_i,
    output logic                  ar_ready_o,
    input  logic [31:0]           aw_addr_i,
    input  logic [7:0]            aw_len_i,
    input  logic [1:0]            aw_burst_i,
    input  logic                  aw_valid_i,
    output logic                  aw_ready_o,
    input  logic [`HB_DATA_W-1:0] w_data_i,
    input  logic [`HB_STRB_W-1:0] w_strb_i,
    input  logic                  w_last_i,
    input  logic                  w_valid_i,
    output logic                  w_ready_o,
    output logic [`HB_DATA_W-1:0] r_data_o,
    output logic                  r_last_o,
    output hb_resp_e              r_resp_o,
    output logic                  r_valid_o,
    input  logic                  r_ready_i,
    output hb_resp_e              b_resp_o,
    output logic                  b_valid_o,
    input  logic                  b_ready_i,
    input  logic                  phy_wr_done_i,
    input  logic                  phy_wr_error_i,
    hyperbus_cmd_if.ctrl          cmd,
    hyperbus_stream_if.src        tx,
    hyperbus_stream_if.dst        rx
);

    hb_state_e   state_q, state_d;
    logic [31:0] addr_q;
    logic [7:0]  len_q;
    logic [1:0]  burst_q;
    logic [8:0]  wr_cnt_q;  // Write beats accepted so far
    logic        wr_err_q;
    logic        rd_beat;
    logic        wr_beat;

    assign rd_beat = rx.valid & rx.ready;
    assign wr_beat = tx.valid & tx.ready;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (ar_valid_i) begin
                    state_d = RD_CMD;
                end else if (aw_valid_i) begin
                    state_d = WR_CMD;
                end
            end
            RD_CMD:  if (cmd.ready) state_d = RD_DATA;
            RD_DATA: if (rd_beat && rx.last) state_d = IDLE;
            WR_CMD:  if (cmd.ready) state_d = WR_DATA;
            WR_DATA: if (wr_beat && tx.last) state_d = WR_WAIT;
            WR_WAIT: if (phy_wr_done_i) state_d = WR_RESP;  // PHY latency varies
            WR_RESP: if (b_ready_i) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= IDLE;
            wr_cnt_q <= '0;
            wr_err_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == IDLE) begin
                wr_cnt_q <= '0;
            end else if (wr_beat) begin
                wr_cnt_q <= wr_cnt_q + 9'd1;
            end
            if (state_q == WR_WAIT && phy_wr_done_i) begin
                wr_err_q <= phy_wr_error_i;
            end
        end
    end

    // Address phase capture, same priority as the FSM
    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            if (ar_valid_i) begin
                addr_q  <= ar_addr_i;
                len_q   <= ar_len_i;
                burst_q <= ar_burst_i;
            end else if (aw_valid_i) begin
                addr_q  <= aw_addr_i;
                len_q   <= aw_len_i;
                burst_q <= aw_burst_i;
            end
        end
    end

    assign cmd.valid      = (state_q == RD_CMD) || (state_q == WR_CMD);
    assign cmd.write      = (state_q == WR_CMD);
    assign cmd.addr       = addr_q;
    assign cmd.len        = len_q;
    assign cmd.burst_type = burst_q;
    assign cmd.cs_n       = ~(`HB_NR_CS'(1) << addr_q[30]);  // Active low one-hot

    assign ar_ready_o = (state_q == RD_CMD) && cmd.ready;
    assign aw_ready_o = (state_q == WR_CMD) && cmd.ready;

    // Read data straight from the rx FIFO
    assign rx.ready  = (state_q == RD_DATA) && r_ready_i;
    assign r_valid_o = (state_q == RD_DATA) && rx.valid;
    assign r_data_o  = rx.data;
    assign r_last_o  = rx.last;
    assign r_resp_o  = rx.error ? RESP_SLVERR : RESP_OKAY;

    assign tx.valid  = (state_q == WR_DATA) && w_valid_i;
    assign tx.data   = w_data_i;
    assign tx.strb   = w_strb_i;
    assign tx.last   = w_last_i;
    assign tx.error  = (wr_cnt_q > {1'b0, len_q});  // Overrun beat
    assign w_ready_o = (state_q == WR_DATA) && tx.ready;

    assign b_valid_o = (state_q == WR_RESP);
    assign b_resp_o  = wr_err_q ? RESP_SLVERR : RESP_OKAY;

    // AXI requires B to stay up until taken
    a_b_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        b_valid_o && !b_ready_i |=> b_valid_o);

    a_one_addr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(ar_ready_o && aw_ready_o));

endmodule

// File: source/hyperbus_if.sv
/*
  Internal links of the bridge. No flow control beyond valid/ready,
  a transfer happens on the clock where both are high.
*/
`timescale 1ns/1ps
`include "hyperbus_defs.svh"

interface hyperbus_cmd_if;
    logic                 valid;
    logic                 ready;
    logic                 write;
    logic [31:0]          addr;        // AXI byte address
    logic [7:0]           len;         // AXI len, beats minus one
    logic [1:0]           burst_type;
    logic [`HB_NR_CS-1:0] cs_n;

    modport ctrl (output valid, write, addr, len, burst_type, cs_n, input ready);
    modport enc  (input valid, write, addr, len, burst_type, cs_n, output ready);
endinterface

interface hyperbus_stream_if;
    logic [`HB_DATA_W-1:0] data;
    logic [`HB_STRB_W-1:0] strb;
    logic                  last;
    logic                  error;
    logic                  valid;
    logic                  ready;

    modport src (output data, strb, last, error, valid, input ready);
    modport dst (input data, strb, last, error, valid, output ready);
endinterface

// File: source/hyperbus_pkg.sv
/*
  Shared types of the bridge. The CA word follows the HyperBus 48-bit layout,
  with the most significant beat sent first.
*/
`include "hyperbus_defs.svh"

package hyperbus_pkg;

    // Field view of the command-address word
    typedef struct packed {
        logic        read;     // 1 for read transactions
        logic        space;    // Register space when set
        logic        linear;   // Linear burst, otherwise wrapped
        logic [28:0] addr_hi;
        logic [12:0] rsvd;
        logic [2:0]  addr_lo;
    } hb_ca_fields_t;

    typedef union packed {
        logic [2:0][`HB_DATA_W-1:0] raw;  // raw[2] goes out first
        hb_ca_fields_t              f;
    } hb_ca_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } hb_resp_e;

    typedef enum logic [2:0] {
        IDLE,
        RD_CMD,
        RD_DATA,
        WR_CMD,
        WR_DATA,
        WR_WAIT,
        WR_RESP
    } hb_state_e;

endpackage

// File: source/hyperbus_defs.svh
/*
  Build-time configuration of the AXI to HyperBus bridge.
  FIFO depths must be powers of two. Credit limits must match the PHY buffers.
*/
`ifndef HYPERBUS_DEFS_SVH
`define HYPERBUS_DEFS_SVH

`define HB_DATA_W      16  // One HyperBus DDR word per beat
`define HB_STRB_W      2
`define HB_BURST_W     12
`define HB_NR_CS       2

// PHY side buffering, in beats
`define HB_CA_CREDITS  4
`define HB_TX_CREDITS  4

`define HB_TX_DEPTH    4
`define HB_RX_DEPTH    4

`endif
